/* source/IntExecTypes.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Integer execution types
// Widths, operation and condition codes, the operation-info
// union and the branch address helpers
// ~~~~~~~~~~~~~~~~~~~~

package IntExecTypes;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;
    localparam int ShiftAmountWidth = 5;
    localparam int ActiveListPtrWidth = 6;
    localparam int InsnByteWidth = 4;
    localparam int LinkOffset = 4;
    // Displacement in half-words
    localparam int BrDispWidth = 20;

    typedef enum logic [2:0] {
        OpAlu,
        OpShift,
        OpBr,
        OpRij,
        OpSelect
    } IntOpType;

    typedef enum logic [2:0] {
        CondEq,
        CondNe,
        CondLt,
        CondLtu,
        CondGe,
        CondGeu,
        CondAl
    } CondCode;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSltu,
        AluPassB
    } AluCode;

    typedef enum logic [1:0] {
        ShiftSll,
        ShiftSrl,
        ShiftSra
    } ShiftKind;

    typedef enum logic {
        OperandReg,
        OperandImm
    } OperandKind;

    // Operand kinds sit in bits 1:0 of both views
    typedef struct packed {
        AluCode                      aluCode;
        ShiftKind                    shiftKind;
        logic                        shiftUseImm;
        logic [ShiftAmountWidth-1:0] shiftImm;
        logic [11:0]                 padding;
        OperandKind                  operandKindA;
        OperandKind                  operandKindB;
    } IntSubInfo;

    typedef struct packed {
        logic [BrDispWidth-1:0] brDisp;
        logic                   predTaken;
        logic [2:0]             padding;
        OperandKind             operandKindA;
        OperandKind             operandKindB;
    } BrSubInfo;

    // Branch view for BR and RIJ, integer view otherwise
    typedef union packed {
        IntSubInfo intInfo;
        BrSubInfo  brInfo;
    } OpInfo;

    // Sign-extend and convert half-words to bytes
    function automatic logic [AddrWidth-1:0] ExtendBranchDisp(
        input logic [BrDispWidth-1:0] disp
    );
        return {{(AddrWidth-BrDispWidth-1){disp[BrDispWidth-1]}}, disp, 1'b0};
    endfunction

    function automatic logic [AddrWidth-1:0] JalrTarget(
        input logic [DataWidth-1:0]   base,
        input logic [BrDispWidth-1:0] disp
    );
        logic [AddrWidth-1:0] sum;
        sum = base + ExtendBranchDisp(disp);
        // Target is always half-word aligned
        sum[0] = 1'b0;
        return sum;
    endfunction

endpackage

/* source/IntAlu.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Integer ALU
// Add, subtract, logic, set-less-than and pass-through
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module IntAlu import IntExecTypes::*; (
    input  AluCode               aluCode,
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,
    output logic [DataWidth-1:0] result
);

    logic signedLess;
    logic unsignedLess;

    always_comb begin
        signedLess = $signed(opA) < $signed(opB);
        unsignedLess = opA < opB;
    end

    always_comb begin
        case (aluCode)
            AluAdd: result = opA + opB;
            AluSub: result = opA - opB;
            AluAnd: result = opA & opB;
            AluOr:  result = opA | opB;
            AluXor: result = opA ^ opB;
            // Set-less-than yields 0 or 1
            AluSlt: begin
                result = {{(DataWidth-1){1'b0}}, signedLess};
            end
            AluSltu: begin
                result = {{(DataWidth-1){1'b0}}, unsignedLess};
            end
            AluPassB: result = opB;
            default: result = '0;
        endcase
    end

endmodule

/* source/IntShifter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Integer shifter
// Logical and arithmetic shifts by an immediate or
// register amount
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module IntShifter import IntExecTypes::*; (
    input  ShiftKind                    shiftKind,
    input  logic                        useImm,
    input  logic [ShiftAmountWidth-1:0] immAmount,
    input  logic [ShiftAmountWidth-1:0] regAmount,
    input  logic [DataWidth-1:0]        dataIn,
    output logic [DataWidth-1:0]        dataOut
);

    logic [ShiftAmountWidth-1:0] amount;

    // Immediate field or low bits of operand B
    always_comb begin
        amount = useImm ? immAmount : regAmount;
    end

    always_comb begin
        case (shiftKind)
            ShiftSll: dataOut = dataIn << amount;
            ShiftSrl: dataOut = dataIn >> amount;
            // Sign bit fills from the left
            ShiftSra: dataOut = DataWidth'($signed(dataIn) >>> amount);
            default:  dataOut = dataIn;
        endcase
    end

endmodule

/* source/BranchResolver.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Branch resolver
// Evaluates the condition, computes the next address and
// detects mispredictions
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module BranchResolver import IntExecTypes::*; (
    input  IntOpType               opType,
    input  CondCode                cond,
    input  logic [BrDispWidth-1:0] brDisp,
    input  logic                   predTaken,
    input  logic [AddrWidth-1:0]   pc,
    input  logic [AddrWidth-1:0]   predAddr,
    input  logic [DataWidth-1:0]   opA,
    input  logic [DataWidth-1:0]   opB,
    input  logic                   active,
    output logic                   condMet,
    output logic                   taken,
    output logic                   isCond,
    output logic [AddrWidth-1:0]   nextAddr,
    output logic                   mispred
);

    logic isBranch;
    logic isJump;
    logic [AddrWidth-1:0] targetAddr;
    logic [AddrWidth-1:0] fallThrough;

    always_comb begin
        case (cond)
            CondEq:  condMet = opA == opB;
            CondNe:  condMet = opA != opB;
            CondLt:  condMet = $signed(opA) < $signed(opB);
            CondLtu: condMet = opA < opB;
            CondGe:  condMet = $signed(opA) >= $signed(opB);
            CondGeu: condMet = opA >= opB;
            // AL and unknown codes always hold
            default: condMet = 1'b1;
        endcase
    end

    always_comb begin
        isBranch = (opType == OpBr) || (opType == OpRij);
        // Unconditional when indirect or BR with AL
        isJump = (opType == OpRij) || (opType == OpBr && cond == CondAl);
        isCond = !isJump;
        taken = isBranch && condMet;
    end

    always_comb begin
        fallThrough = pc + AddrWidth'(InsnByteWidth);
        if (opType == OpBr) begin
            targetAddr = pc + ExtendBranchDisp(brDisp);
        end else begin
            targetAddr = JalrTarget(opA, brDisp);
        end
        nextAddr = taken ? targetAddr : fallThrough;
    end

    // Wrong direction, or taken to the wrong place
    always_comb begin
        mispred = active && isBranch &&
            ((predTaken != taken) || (taken && predAddr != nextAddr));
    end

endmodule

/* source/IntExecStage.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Integer execution stage
// Pipeline register, operand bypass, result select,
// replay marking and selective flush
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module IntExecStage import IntExecTypes::*; (
    input  logic                          clk,
    input  logic                          rstN,
    // From register read
    input  logic                          inValid,
    input  IntOpType                      inOpType,
    input  CondCode                       inCond,
    input  OpInfo                         inOpInfo,
    input  logic [AddrWidth-1:0]          inPc,
    input  logic [AddrWidth-1:0]          inPredAddr,
    input  logic [ActiveListPtrWidth-1:0] inActiveListPtr,
    input  logic [DataWidth-1:0]          inOperandA,
    input  logic                          inOperandAValid,
    input  logic [DataWidth-1:0]          inOperandB,
    input  logic                          inOperandBValid,
    input  logic                          inBypassA,
    input  logic                          inBypassB,
    // Bypass network
    input  logic [DataWidth-1:0]          bypassDataA,
    input  logic [DataWidth-1:0]          bypassDataB,
    input  logic                          bypassValidA,
    input  logic                          bypassValidB,
    // Controller and recovery
    input  logic                          stall,
    input  logic                          clear,
    input  logic                          toRecoveryPhase,
    input  logic [ActiveListPtrWidth-1:0] flushHeadPtr,
    input  logic [ActiveListPtrWidth-1:0] flushTailPtr,
    // Results
    output logic                          outValid,
    output logic [DataWidth-1:0]          outData,
    output logic                          outDataValid,
    output logic                          brValid,
    output logic                          brTaken,
    output logic                          brIsCond,
    output logic [AddrWidth-1:0]          brNextAddr,
    output logic                          brMispred
);

    logic                          rValid;
    IntOpType                      rOpType;
    CondCode                       rCond;
    OpInfo                         rOpInfo;
    logic [AddrWidth-1:0]          rPc;
    logic [AddrWidth-1:0]          rPredAddr;
    logic [ActiveListPtrWidth-1:0] rActiveListPtr;
    logic [DataWidth-1:0]          rOperandA;
    logic [DataWidth-1:0]          rOperandB;
    logic                          rOperandAValid;
    logic                          rOperandBValid;
    logic                          rBypassA;
    logic                          rBypassB;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rValid <= 1'b0;
        end else if (!stall) begin
            rValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rOpType <= inOpType;
            rCond <= inCond;
            rOpInfo <= inOpInfo;
            rPc <= inPc;
            rPredAddr <= inPredAddr;
            rActiveListPtr <= inActiveListPtr;
            rOperandA <= inOperandA;
            rOperandB <= inOperandB;
            rOperandAValid <= inOperandAValid;
            rOperandBValid <= inOperandBValid;
            rBypassA <= inBypassA;
            rBypassB <= inBypassB;
        end
    end

    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    logic opAValid;
    logic opBValid;
    IntSubInfo intInfo;
    BrSubInfo brInfo;
    logic regsValid;
    logic isBranch;
    logic [ActiveListPtrWidth-1:0] ptrOffset;
    logic [ActiveListPtrWidth-1:0] rangeSpan;
    logic flush;
    logic active;

    always_comb begin
        // Live bypass values when selected
        opA = rBypassA ? bypassDataA : rOperandA;
        opB = rBypassB ? bypassDataB : rOperandB;
        opAValid = rBypassA ? bypassValidA : rOperandAValid;
        opBValid = rBypassB ? bypassValidB : rOperandBValid;
        intInfo = rOpInfo.intInfo;
        brInfo = rOpInfo.brInfo;
        // Invalid register source means replay
        regsValid = (intInfo.operandKindA != OperandReg || opAValid) &&
                    (intInfo.operandKindB != OperandReg || opBValid);
        isBranch = (rOpType == OpBr) || (rOpType == OpRij);
    end

    // Circular range head..tail-1, modulo list size
    always_comb begin
        ptrOffset = rActiveListPtr - flushHeadPtr;
        rangeSpan = flushTailPtr - flushHeadPtr;
        flush = toRecoveryPhase && (ptrOffset < rangeSpan);
        active = rValid && !clear && !flush;
    end

    logic [DataWidth-1:0] aluResult;
    logic [DataWidth-1:0] shiftResult;
    logic condMet;
    logic mispred;

    IntAlu alu (
        .aluCode (intInfo.aluCode),
        .opA     (opA),
        .opB     (opB),
        .result  (aluResult)
    );

    IntShifter shifter (
        .shiftKind (intInfo.shiftKind),
        .useImm    (intInfo.shiftUseImm),
        .immAmount (intInfo.shiftImm),
        .regAmount (opB[ShiftAmountWidth-1:0]),
        .dataIn    (opA),
        .dataOut   (shiftResult)
    );

    BranchResolver brResolver (
        .opType    (rOpType),
        .cond      (rCond),
        .brDisp    (brInfo.brDisp),
        .predTaken (brInfo.predTaken),
        .pc        (rPc),
        .predAddr  (rPredAddr),
        .opA       (opA),
        .opB       (opB),
        .active    (active),
        .condMet   (condMet),
        .taken     (brTaken),
        .isCond    (brIsCond),
        .nextAddr  (brNextAddr),
        .mispred   (mispred)
    );

    always_comb begin
        case (rOpType)
            OpAlu:   outData = aluResult;
            OpShift: outData = shiftResult;
            // Link address
            OpBr, OpRij: outData = rPc + AddrWidth'(LinkOffset);
            default: outData = condMet ? opA : opB;
        endcase
    end

    always_comb begin
        outValid = rValid && !stall && !clear && !flush;
        outDataValid = regsValid;
        brValid = rValid && isBranch && regsValid;
        brMispred = mispred;
    end

endmodule

/* tests/IntExecStageTb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Integer execution stage testbench
// Replays operations from a trace file and checks each result
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module IntExecStageTb import IntExecTypes::*; ();

    logic clk = 1'b0;
    logic rstN;
    logic inValid;
    IntOpType inOpType;
    CondCode inCond;
    OpInfo inOpInfo;
    logic [AddrWidth-1:0] inPc, inPredAddr;
    logic [ActiveListPtrWidth-1:0] inActiveListPtr, flushHeadPtr, flushTailPtr;
    logic [DataWidth-1:0] inOperandA, inOperandB, bypassDataA, bypassDataB;
    logic inOperandAValid, inOperandBValid, inBypassA, inBypassB;
    logic bypassValidA, bypassValidB, stall, clear, toRecoveryPhase;
    logic outValid, outDataValid, brValid, brTaken, brIsCond, brMispred;
    logic [DataWidth-1:0] outData;
    logic [AddrWidth-1:0] brNextAddr;

    // Fields of the current trace line
    logic [31:0] ctrl, opTypeVal, condVal, infoVal, pcVal, predVal;
    logic [31:0] ptrVal, headVal, tailVal, opAVal, opBVal;
    logic [31:0] expFlags, expData, expNext;

    string traceLines[$];
    int passCount = 0;
    int failCount = 0;
    logic testFailed;
    logic traceReady = 1'b0;

    IntExecStage dut (.*);

    always #4 clk = ~clk;

    task automatic readTrace();
        int fd;
        string line;
        fd = $fopen("tests/intExecTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tests/intExecTrace.txt");
            failCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 2 && line[0] != "#") begin
                    traceLines.push_back(line);
                end
            end
            $fclose(fd);
        end
        traceReady = 1'b1;
    endtask

    task automatic driveOperation();
        inValid <= ctrl[0];
        inOpType <= IntOpType'(opTypeVal[2:0]);
        inCond <= CondCode'(condVal[2:0]);
        inOpInfo <= infoVal[25:0];
        inPc <= pcVal;
        inPredAddr <= predVal;
        inActiveListPtr <= ptrVal[ActiveListPtrWidth-1:0];
        inOperandAValid <= ctrl[1];
        inOperandBValid <= ctrl[2];
        inBypassA <= ctrl[3];
        inBypassB <= ctrl[4];
        bypassValidA <= ctrl[5];
        bypassValidB <= ctrl[6];
        // Unselected source of each operand carries random data
        inOperandA <= ctrl[3] ? $urandom : opAVal;
        bypassDataA <= ctrl[3] ? opAVal : $urandom;
        inOperandB <= ctrl[4] ? $urandom : opBVal;
        bypassDataB <= ctrl[4] ? opBVal : $urandom;
        flushHeadPtr <= headVal[ActiveListPtrWidth-1:0];
        flushTailPtr <= tailVal[ActiveListPtrWidth-1:0];
        // Hold line keeps the previous operation in the register
        stall <= ctrl[10];
        clear <= 1'b0;
        toRecoveryPhase <= 1'b0;
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected);
            testFailed = 1'b1;
        end
    endtask

    task automatic checkOutputs();
        checkField("outValid", outValid, expFlags[0]);
        checkField("outDataValid", outDataValid, expFlags[1]);
        checkField("brValid", brValid, expFlags[2]);
        checkField("brTaken", brTaken, expFlags[3]);
        checkField("brIsCond", brIsCond, expFlags[4]);
        checkField("brMispred", brMispred, expFlags[5]);
        checkField("outData", outData, expData);
        checkField("brNextAddr", brNextAddr, expNext);
    endtask

    task automatic reportTest(input string name);
        if (testFailed) begin
            failCount++;
            $display("%s failed", name);
        end else begin
            passCount++;
            $display("%s passed", name);
        end
    endtask

    // Load on one edge, live controls on the next, check mid-cycle
    task automatic runTest(input int idx);
        int count;
        count = $sscanf(traceLines[idx], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            ctrl, opTypeVal, condVal, infoVal, pcVal, predVal, ptrVal, headVal,
            tailVal, opAVal, opBVal, expFlags, expData, expNext);
        testFailed = 1'b0;
        if (count != 14) begin
            $display("Trace line %0d could not be parsed", idx + 1);
            testFailed = 1'b1;
        end else begin
            @(posedge clk);
            driveOperation();
            @(posedge clk);
            stall <= ctrl[7];
            clear <= ctrl[8];
            toRecoveryPhase <= ctrl[9];
            @(negedge clk);
            checkOutputs();
        end
        reportTest($sformatf("Trace test %0d", idx + 1));
    endtask

    initial begin
        void'($urandom(32'hb96e));
        rstN = 1'b0;
        {ctrl, opTypeVal, condVal, infoVal, pcVal, predVal} = '0;
        {ptrVal, headVal, tailVal, opAVal, opBVal} = '0;
        // A mispredicting branch waits at the inputs while reset holds the register
        ctrl = 32'h7;
        opTypeVal = 32'h2;
        driveOperation();
        readTrace();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        // Nothing valid right after reset
        @(negedge clk);
        testFailed = 1'b0;
        checkField("outValid", outValid, 0);
        checkField("brValid", brValid, 0);
        checkField("brMispred", brMispred, 0);
        reportTest("Reset test");
        foreach (traceLines[i]) begin
            runTest(i);
        end
        $display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Two cycles per trace line, plus reset and margin
    initial begin
        wait (traceReady);
        #((2 * traceLines.size() + 20) * 8);
        $display("Timeout: the trace did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* tests/intExecTrace.txt */
# ctrl type cond opInfo pc predAddr alPtr flushHead flushTail opA opB expFlags expData expNext
# ctrl bits 0..10: valid aValid bValid bypA bypB bypValidA bypValidB stall clear recovery hold
# expFlags bits 0..5: outValid outDataValid brValid brTaken brIsCond brMispred
007 0 0 0000000 00001000 00000000 00 00 00 00000005 00000007 13 0000000C 00001004
007 0 0 0400000 00001000 00000000 00 00 00 00000003 00000005 13 FFFFFFFE 00001004
007 0 0 0800001 00001000 00000000 00 00 00 F0F0F0F0 0000FF00 13 0000F000 00001004
007 0 0 0C00000 00001000 00000000 00 00 00 12340000 00005678 13 12345678 00001004
007 0 0 1000000 00001000 00000000 00 00 00 FFFF0000 0F0F0F0F 13 F0F00F0F 00001004
007 0 0 1400000 00001000 00000000 00 00 00 FFFFFFFF 00000001 13 00000001 00001004
007 0 0 1800000 00001000 00000000 00 00 00 FFFFFFFF 00000001 13 00000000 00001004
007 0 0 1C00001 00001000 00000000 00 00 00 00000000 0000ABCD 13 0000ABCD 00001004
007 1 0 0090001 00001000 00000000 00 00 00 0000000F 00000000 13 000000F0 00001004
007 1 0 02A0001 00001000 00000000 00 00 00 80000010 00000000 13 FF800000 00001004
007 1 0 0100000 00001000 00000000 00 00 00 80000000 FFFFFFE4 13 08000000 00001004
007 1 0 0200000 00001000 00000000 00 00 00 F0000000 0000001C 13 FFFFFFFF 00001004
079 0 0 0000000 00001000 00000000 00 00 00 00000100 00000023 13 00000123 00001004
00D 0 0 0000000 00001000 00000000 00 00 00 00000001 00000002 11 00000003 00001004
003 0 0 0000001 00001000 00000000 00 00 00 00000010 00000020 13 00000030 00001004
003 0 0 0400000 00001000 00000000 00 00 00 00000009 00000004 11 00000005 00001004
007 4 0 0000000 00001000 00000000 00 00 00 00000005 00000006 13 00000006 00001004
007 4 1 0000000 00001000 00000000 00 00 00 00000005 00000006 13 00000005 00001004
007 4 2 0000000 00001000 00000000 00 00 00 FFFFFFF0 00000010 13 FFFFFFF0 00001004
007 4 3 0000000 00001000 00000000 00 00 00 FFFFFFF0 00000010 13 00000010 00001004
007 4 4 0000000 00001000 00000000 00 00 00 00000010 FFFFFFF0 13 00000010 00001004
007 4 5 0000000 00001000 00000000 00 00 00 00000010 FFFFFFF0 13 FFFFFFF0 00001004
007 4 6 0000000 00001000 00000000 00 00 00 11111111 22222222 13 11111111 00001004
007 2 0 0000820 00001000 00001040 00 00 00 00000007 00000007 1F 00001004 00001040
007 2 1 0000820 00001000 00001040 00 00 00 00000007 00000007 37 00001004 00001004
007 2 2 3FFFC00 00001000 00000000 00 00 00 FFFFFFFF 00000001 3F 00001004 00000FE0
007 2 6 0004020 00001000 00001100 00 00 00 00000000 00000000 2F 00001004 00001200
003 3 6 0000121 00001000 00002008 00 00 00 00002001 00000000 0F 00001004 00002008
087 0 0 0000000 00001000 00000000 00 00 00 00000011 00000022 12 00000033 00001004
407 0 0 0000000 00002000 00000000 00 00 00 00000100 00000200 13 00000033 00001004
107 2 1 0000820 00001000 00001040 00 00 00 00000007 00000007 16 00001004 00001004
207 2 1 0000820 00001000 00001040 05 03 08 00000007 00000007 16 00001004 00001004
207 2 1 0000820 00001000 00001040 01 3C 04 00000007 00000007 16 00001004 00001004
207 2 1 0000820 00001000 00001040 10 3C 04 00000007 00000007 37 00001004 00001004

/* list.f */
source/IntExecTypes.sv
source/IntAlu.sv
source/IntShifter.sv
source/BranchResolver.sv
source/IntExecStage.sv
tests/IntExecStageTb.sv

/* Bender.yml */
package:
  name: int_exec_stage

sources:
  - source/IntExecTypes.sv
  - source/IntAlu.sv
  - source/IntShifter.sv
  - source/BranchResolver.sv
  - source/IntExecStage.sv
  - target: test
    files:
      - tests/IntExecStageTb.sv
